//--- organ_pkg.sv
package organ_pkg;

  // ==========================================================================
  // Data types
  // ==========================================================================
  typedef logic signed [7:0]  sample_t;
  typedef logic        [15:0] count_t;
  typedef logic signed [15:0] speed_t;
  typedef logic        [3:0]  apb_addr_t;
  typedef logic        [31:0] apb_data_t;
  typedef logic        [2:0]  note_idx_t;

  // One 24-bit word, seen as a number or as six hex digits
  typedef union packed {
    logic [23:0]      value;
    logic [5:0][3:0]  digit;
  } hex_word_u;

  // ==========================================================================
  // Audio
  // ==========================================================================
  localparam sample_t SAMPLE_HIGH = 8'sh7F;
  localparam sample_t SAMPLE_LOW  = 8'sh80;
  localparam sample_t SAMPLE_OFF  = 8'sh00;

  // Half periods in 50 MHz cycles, C5 up to C6
  localparam logic [15:0] NOTE_HALF_PERIOD [0:7] = '{
    16'd47778, 16'd42566, 16'd37922, 16'd35793,
    16'd31888, 16'd28409, 16'd25310, 16'd23889
  };

  // ==========================================================================
  // Speed control and register map
  // ==========================================================================
  localparam count_t DEFAULT_SAMPLE_COUNT = 16'd12499;
  localparam speed_t DEFAULT_SPEED_STEP   = 16'sd100;

  localparam apb_addr_t ADDR_CTRL  = 4'h0;
  localparam apb_addr_t ADDR_STEP  = 4'h4;
  localparam apb_addr_t ADDR_COUNT = 4'h8;

  // Active-low segments, bit 6 is g and bit 0 is a
  localparam logic [6:0] seg_patterns [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

//--- organ_regs.sv
`timescale 1ns/10ps

module organ_regs (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  organ_pkg::apb_addr_t  paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  organ_pkg::apb_data_t  pwdata,
  input  organ_pkg::count_t     sample_count,
  output organ_pkg::apb_data_t  prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  audio_en,
  output organ_pkg::note_idx_t  note_idx,
  output organ_pkg::speed_t     speed_step
);

  logic                  access;
  logic                  hit_ctrl;
  logic                  hit_step;
  logic                  hit_count;
  logic                  mapped;
  organ_pkg::hex_word_u  count_word;

  // Address decode
  assign hit_ctrl  = (paddr == organ_pkg::ADDR_CTRL);
  assign hit_step  = (paddr == organ_pkg::ADDR_STEP);
  assign hit_count = (paddr == organ_pkg::ADDR_COUNT);
  assign mapped    = hit_ctrl | hit_step | hit_count;

  // Access phase of a transfer
  assign access  = psel & penable;
  assign pready  = 1'b1;
  assign pslverr = access & ~mapped;

  // ==========================================================================
  // Control and step registers
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      audio_en   <= 1'b0;
      note_idx   <= '0;
      speed_step <= organ_pkg::DEFAULT_SPEED_STEP;
    end
    else if (access && pwrite)
    begin
      if (hit_ctrl)
      begin
        audio_en <= pwdata[0];
        note_idx <= pwdata[3:1];
      end
      if (hit_step)
      begin
        speed_step <= organ_pkg::speed_t'(pwdata[15:0]);
      end
    end
  end

  // Count readback, zero-extended to the display width
  always_comb
  begin
    count_word.value = {8'h00, sample_count};
  end

  // Read data mux
  always_comb
  begin
    prdata = '0;
    if (psel)
    begin
      case (paddr)
        organ_pkg::ADDR_CTRL:  prdata = {28'h0, note_idx, audio_en};
        organ_pkg::ADDR_STEP:  prdata = {16'h0, speed_step};
        organ_pkg::ADDR_COUNT: prdata = {8'h00, count_word.value};
        default:               prdata = '0;
      endcase
    end
  end

endmodule

//--- tone_gen.sv
`timescale 1ns/10ps

module tone_gen (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  audio_en,
  input  organ_pkg::note_idx_t  note_idx,
  output organ_pkg::sample_t    audio_sample
);

  logic [15:0] half_cnt;
  logic        phase;
  logic [15:0] reload_val;

  // Picked up only at reload, so a new note starts at the next toggle
  assign reload_val = organ_pkg::NOTE_HALF_PERIOD[note_idx] - 16'd1;

  // Half-period down-counter and square-wave phase
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      phase    <= 1'b0;
    end
    else if (!audio_en)
    begin
      // Parked while muted, first edge one full half period after enable
      half_cnt <= reload_val;
      phase    <= 1'b0;
    end
    else if (half_cnt == 16'd0)
    begin
      half_cnt <= reload_val;
      phase    <= ~phase;
    end
    else
    begin
      half_cnt <= half_cnt - 16'd1;
    end
  end

  // Signed sample from the phase
  assign audio_sample = !audio_en ? organ_pkg::SAMPLE_OFF :
                        phase     ? organ_pkg::SAMPLE_HIGH :
                                    organ_pkg::SAMPLE_LOW;

endmodule

//--- speed_ctrl.sv
`timescale 1ns/10ps

module speed_ctrl #(
  parameter int TICK_DIV    = 50000,
  parameter int EVENT_TICKS = 100
) (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  logic               key_up_n,
  input  logic               key_down_n,
  input  logic               key_reset_n,
  input  organ_pkg::speed_t  speed_step,
  output organ_pkg::count_t  sample_count
);

  localparam int TICK_W  = $clog2(TICK_DIV + 1);
  localparam int EVENT_W = $clog2(EVENT_TICKS + 1);

  logic [1:0]         up_sync;
  logic [1:0]         down_sync;
  logic [1:0]         reset_sync;
  logic               key_up;
  logic               key_down;
  logic               key_reset;
  logic [TICK_W-1:0]  tick_cnt;
  logic [EVENT_W-1:0] event_cnt;
  logic               tick;
  logic               repeat_event;
  organ_pkg::speed_t  speed;

  // ==========================================================================
  // Key synchronizers, keys idle high
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      up_sync    <= 2'b11;
      down_sync  <= 2'b11;
      reset_sync <= 2'b11;
    end
    else
    begin
      up_sync    <= {up_sync[0], key_up_n};
      down_sync  <= {down_sync[0], key_down_n};
      reset_sync <= {reset_sync[0], key_reset_n};
    end
  end

  assign key_up    = ~up_sync[1];
  assign key_down  = ~down_sync[1];
  assign key_reset = ~reset_sync[1];

  // ==========================================================================
  // Slow tick and repeat event
  // ==========================================================================
  assign tick         = (tick_cnt == TICK_W'(TICK_DIV - 1));
  assign repeat_event = tick && (event_cnt == EVENT_W'(EVENT_TICKS - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt  <= '0;
      event_cnt <= '0;
    end
    else
    begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (repeat_event)
        event_cnt <= '0;
      else if (tick)
        event_cnt <= event_cnt + 1'b1;
    end
  end

  // Speed accumulator, both keys held cancel out
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || key_reset)
    begin
      speed <= '0;
    end
    else if (repeat_event)
    begin
      case ({key_up, key_down})
        2'b10:   speed <= speed + speed_step;
        2'b01:   speed <= speed - speed_step;
        default: speed <= speed;
      endcase
    end
  end

  // Sampling count trails the speed by one cycle
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_count <= organ_pkg::DEFAULT_SAMPLE_COUNT;
    else
      sample_count <= organ_pkg::DEFAULT_SAMPLE_COUNT + organ_pkg::count_t'(speed);
  end

endmodule

//--- hex_display.sv
`timescale 1ns/10ps

module hex_display #(
  parameter int DISP_DIV = 25000000
) (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  organ_pkg::count_t  sample_count,
  output logic [6:0]         hex0,
  output logic [6:0]         hex1,
  output logic [6:0]         hex2,
  output logic [6:0]         hex3,
  output logic [6:0]         hex4,
  output logic [6:0]         hex5
);

  localparam int REFRESH_W = $clog2(DISP_DIV + 1);

  logic [REFRESH_W-1:0]  refresh_cnt;
  logic                  refresh;
  organ_pkg::hex_word_u  disp_word;

  assign refresh = (refresh_cnt == REFRESH_W'(DISP_DIV - 1));

  // ==========================================================================
  // Refresh counter and display latch
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      disp_word   <= '0;
    end
    else
    begin
      refresh_cnt <= refresh ? '0 : refresh_cnt + 1'b1;
      if (refresh)
        disp_word.value <= {8'h00, sample_count};
    end
  end

  // Seven-segment decode, digit 0 is the least significant
  assign hex0 = organ_pkg::seg_patterns[disp_word.digit[0]];
  assign hex1 = organ_pkg::seg_patterns[disp_word.digit[1]];
  assign hex2 = organ_pkg::seg_patterns[disp_word.digit[2]];
  assign hex3 = organ_pkg::seg_patterns[disp_word.digit[3]];
  assign hex4 = organ_pkg::seg_patterns[disp_word.digit[4]];
  assign hex5 = organ_pkg::seg_patterns[disp_word.digit[5]];

endmodule

//--- basic_organ_top.sv
`timescale 1ns/10ps

module basic_organ_top #(
  parameter int TICK_DIV    = 50000,
  parameter int EVENT_TICKS = 100,
  parameter int DISP_DIV    = 25000000
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  // APB slave
  input  organ_pkg::apb_addr_t  paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  organ_pkg::apb_data_t  pwdata,
  output organ_pkg::apb_data_t  prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Push buttons, active low
  input  logic                  key_up_n,
  input  logic                  key_down_n,
  input  logic                  key_reset_n,
  // Audio and display
  output organ_pkg::sample_t    audio_sample,
  output logic [6:0]            hex0,
  output logic [6:0]            hex1,
  output logic [6:0]            hex2,
  output logic [6:0]            hex3,
  output logic [6:0]            hex4,
  output logic [6:0]            hex5
);

  logic                  audio_en;
  organ_pkg::note_idx_t  note_idx;
  organ_pkg::speed_t     speed_step;
  organ_pkg::count_t     sample_count;

  // ==========================================================================
  // Register block
  // ==========================================================================
  organ_regs u_regs (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .sample_count (sample_count),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .audio_en     (audio_en),
    .note_idx     (note_idx),
    .speed_step   (speed_step)
  );

  // Square-wave voice
  tone_gen u_tone (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .audio_en     (audio_en),
    .note_idx     (note_idx),
    .audio_sample (audio_sample)
  );

  // ==========================================================================
  // Sampling speed and its display
  // ==========================================================================
  speed_ctrl #(
    .TICK_DIV    (TICK_DIV),
    .EVENT_TICKS (EVENT_TICKS)
  ) u_speed (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_reset_n  (key_reset_n),
    .speed_step   (speed_step),
    .sample_count (sample_count)
  );

  hex_display #(
    .DISP_DIV (DISP_DIV)
  ) u_display (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

//--- tb_basic_organ.sv
`timescale 1ns/10ps

module tb_basic_organ;

  localparam int TICK_DIV    = 4;
  localparam int EVENT_TICKS = 5;
  localparam int DISP_DIV    = 64;
  localparam int BASE_COUNT  = 12499;

  logic                  CLK_50M = 1'b0;
  logic                  rst_n;
  organ_pkg::apb_addr_t  paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  organ_pkg::apb_data_t  pwdata;
  organ_pkg::apb_data_t  prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  key_up_n;
  logic                  key_down_n;
  logic                  key_reset_n;
  organ_pkg::sample_t    audio_sample;
  logic [6:0]            hex0;
  logic [6:0]            hex1;
  logic [6:0]            hex2;
  logic [6:0]            hex3;
  logic [6:0]            hex4;
  logic [6:0]            hex5;

  integer seed          = 32'h620f_06a2;
  int     err_cnt       = 0;
  int     err_mark      = 0;
  int     test_cnt      = 0;
  int     test_fail_cnt = 0;

  basic_organ_top #(
    .TICK_DIV    (TICK_DIV),
    .EVENT_TICKS (EVENT_TICKS),
    .DISP_DIV    (DISP_DIV)
  ) UUT (
    .CLK_50M (CLK_50M), .rst_n (rst_n),
    .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .key_up_n (key_up_n), .key_down_n (key_down_n), .key_reset_n (key_reset_n),
    .audio_sample (audio_sample),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
  );

  // 50 MHz
  always #10 CLK_50M = ~CLK_50M;

  // ==========================================================================
  // Compare tasks and bookkeeping
  // ==========================================================================
  task automatic check_count(input string name, input organ_pkg::count_t got,
                             input organ_pkg::count_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_sample(input string name, input organ_pkg::sample_t got,
                              input organ_pkg::sample_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_seg(input string name, input logic [6:0] got, input logic [6:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_data(input string name, input organ_pkg::apb_data_t got,
                            input organ_pkg::apb_data_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %s", msg);
    err_cnt++;
  endtask

  task automatic begin_test();
    err_mark = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_mark)
      $display("test %0d %s: ok", test_cnt, name);
    else
    begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
      test_fail_cnt++;
    end
  endtask

  // ==========================================================================
  // APB master with a setup cycle and an access cycle
  // ==========================================================================
  task automatic apb_write(input organ_pkg::apb_addr_t addr, input organ_pkg::apb_data_t data);
    @(negedge CLK_50M);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge CLK_50M);
    penable = 1'b1;
    @(negedge CLK_50M);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input organ_pkg::apb_addr_t addr, output organ_pkg::apb_data_t data,
                          output logic err);
    @(negedge CLK_50M);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge CLK_50M);
    penable = 1'b1;
    // Read data is combinational during the access cycle
    #1;
    data = prdata;
    err  = pslverr;
    check_flag("pready", pready, 1'b1);
    @(negedge CLK_50M);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic verify_reset_values();
    organ_pkg::apb_data_t data;
    logic                 err;
    begin_test();
    apb_read(4'h8, data, err);
    check_data("COUNT", data, 32'd12499);
    check_flag("pslverr", err, 1'b0);
    apb_read(4'h0, data, err);
    check_data("CTRL", data, 32'h0);
    check_flag("pslverr", err, 1'b0);
    apb_read(4'h4, data, err);
    check_data("STEP", data, 32'd100);
    check_flag("pslverr", err, 1'b0);
    check_sample("audio_sample", audio_sample, 8'sh00);
    apb_read(4'hC, data, err);
    check_flag("pslverr", err, 1'b1);
    end_test("reset values");
  endtask

  task automatic measure_tone_period();
    organ_pkg::sample_t prev;
    organ_pkg::sample_t first;
    organ_pkg::count_t  cycles;
    int                 waited;
    begin_test();
    // Enable in bit 0 and note 5 in bits 3:1
    apb_write(4'h0, 32'h0000_000B);
    prev   = audio_sample;
    waited = 0;
    while (audio_sample === prev && waited < 60000)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    first  = audio_sample;
    cycles = 0;
    while (audio_sample === first && cycles < 16'd60000)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (first === prev || audio_sample === first)
      report_error("audio_sample did not toggle twice within the timeout");
    else if (first !== 8'sh7F && first !== 8'sh80)
      report_error("audio_sample toggled to a value that is neither high nor low");
    else
    begin
      check_sample("audio_sample", audio_sample, (first == 8'sh7F) ? 8'sh80 : 8'sh7F);
      check_count("half period cycles", cycles, 16'd28409);
    end
    apb_write(4'h0, 32'h0);
    check_sample("audio_sample", audio_sample, 8'sh00);
    end_test("tone");
  endtask

  task automatic exercise_speed_keys();
    organ_pkg::apb_data_t data;
    logic                 err;
    int                   step;
    int                   diff;
    int                   tries;
    begin_test();
    step = 1 + ({$random(seed)} % 200);
    apb_write(4'h4, step);
    key_up_n = 1'b0;
    data     = BASE_COUNT;
    tries    = 0;
    while (int'(data[15:0]) == BASE_COUNT && tries < 100)
    begin
      apb_read(4'h8, data, err);
      tries++;
    end
    key_up_n = 1'b1;
    repeat (6) @(negedge CLK_50M);
    apb_read(4'h8, data, err);
    diff = int'(data[15:0]) - BASE_COUNT;
    if (diff / step < 1)
      report_error("COUNT did not rise while the up key was held");
    else
      check_count("COUNT", data[15:0], organ_pkg::count_t'(BASE_COUNT + (diff / step) * step));
    key_down_n = 1'b0;
    tries      = 0;
    while (int'(data[15:0]) >= BASE_COUNT && tries < 200)
    begin
      apb_read(4'h8, data, err);
      tries++;
    end
    key_down_n = 1'b1;
    repeat (6) @(negedge CLK_50M);
    apb_read(4'h8, data, err);
    diff = int'(data[15:0]) - BASE_COUNT;
    if (diff / step > -1)
      report_error("COUNT did not fall below its default while the down key was held");
    else
      check_count("COUNT", data[15:0], organ_pkg::count_t'(BASE_COUNT + (diff / step) * step));
    end_test("speed up and down");
  endtask

  task automatic pulse_speed_reset();
    organ_pkg::apb_data_t data;
    logic                 err;
    begin_test();
    key_reset_n = 1'b0;
    repeat (5) @(negedge CLK_50M);
    key_reset_n = 1'b1;
    repeat (4) @(negedge CLK_50M);
    apb_read(4'h8, data, err);
    check_count("COUNT", data[15:0], 16'd12499);
    end_test("speed reset");
  endtask

  task automatic compare_display();
    organ_pkg::apb_data_t data;
    logic                 err;
    organ_pkg::hex_word_u word;
    logic [6:0]           exp_seg [0:5];
    int                   i;
    int                   waited;
    begin_test();
    apb_read(4'h8, data, err);
    check_count("COUNT", data[15:0], organ_pkg::count_t'(BASE_COUNT));
    word.value = 24'(BASE_COUNT);
    for (i = 0; i < 6; i++)
      exp_seg[i] = organ_pkg::seg_patterns[word.value[4*i +: 4]];
    waited = 0;
    while ({hex5, hex4, hex3, hex2, hex1, hex0} !==
           {exp_seg[5], exp_seg[4], exp_seg[3], exp_seg[2], exp_seg[1], exp_seg[0]} &&
           waited < 4 * DISP_DIV)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    if (waited >= 4 * DISP_DIV)
      report_error("display did not show COUNT within the timeout");
    check_seg("hex0", hex0, exp_seg[0]);
    check_seg("hex1", hex1, exp_seg[1]);
    check_seg("hex2", hex2, exp_seg[2]);
    check_seg("hex3", hex3, exp_seg[3]);
    check_seg("hex4", hex4, exp_seg[4]);
    check_seg("hex5", hex5, exp_seg[5]);
    end_test("display");
  endtask

  initial
  begin
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    key_up_n    = 1'b1;
    key_down_n  = 1'b1;
    key_reset_n = 1'b1;
    repeat (2) @(negedge CLK_50M);
    rst_n = 1'b1;

    verify_reset_values();
    measure_tone_period();
    exercise_speed_keys();
    pulse_speed_reset();
    compare_display();

    $display("tests run: %0d, tests failed: %0d, checks failed: %0d",
             test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- basic_organ_top.f
organ_pkg.sv
organ_regs.sv
tone_gen.sv
speed_ctrl.sv
hex_display.sv
basic_organ_top.sv
tb_basic_organ.sv

//--- Makefile
TB    = tb_basic_organ
FLIST = basic_organ_top.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module basic_organ_top -f $(FLIST)

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TB) -f $(FLIST) -o $(TB)
	./obj_dir/$(TB) | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
